/* compile.f */
+incdir+include
src/mmu_pkg.sv
src/dtlb.sv
src/access_check.sv
src/mmu_top.sv
test/mmu_tb.sv

/* Bender.yml */
package:
  name: mmu_dtlb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/mmu_pkg.sv
      - src/dtlb.sv
      - src/access_check.sv
      - src/mmu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/mmu_tb.sv

/* test/mmu_tb.sv */
// Self-checking testbench for the data translation path against a reference TLB model
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module mmu_tb
  import mmu_pkg::*;
  ();

  localparam int clk_period_lp   = 40;
  localparam int reset_cycles_lp = 16;
  localparam int vtag_w_lp       = `MMU_VTAG_WIDTH;
  localparam int ptag_w_lp       = `MMU_PTAG_WIDTH;
  localparam int off_w_lp        = `MMU_PAGE_OFFSET_WIDTH;
  localparam int did_w_lp        = `MMU_DID_WIDTH;
  localparam int tlb_n_lp        = `MMU_TLB_ENTRIES;
  localparam int pool_n_lp       = 12;
  localparam int n_rand_lp       = 24;
  localparam int n_stream_lp     = 32;
  localparam int cmd_total_lp    = 2 * n_rand_lp + 10 + 3 * pool_n_lp + 5 * 16
                                 + 2 * n_stream_lp;
  localparam int watchdog_ns_lp  = cmd_total_lp * 200 + reset_cycles_lp * clk_period_lp;

  // Expected response and the rising edge at which it is sampled
  typedef struct packed {
    int unsigned due;
    mmu_resp_s   resp;
  } expect_s;

  logic        clk_i;
  logic        reset_i;
  logic        cmd_v_i;
  mmu_cmd_s    cmd_i;
  logic        fill_v_i;
  tlb_fill_s   fill_i;
  logic        flush_i;
  logic        translation_en_i;
  priv_mode_e  priv_mode_i;
  logic        mstatus_sum_i;
  logic        uncached_mode_i;
  logic        poison_i;
  logic        resp_v_o;
  mmu_resp_s   resp_o;

  integer      seed;
  int unsigned edge_cnt = 0;
  expect_s     exp_q [$];
  logic        exp_v;
  mmu_resp_s   exp_resp;

  // Reference copy of the TLB
  logic                 copy_valid [tlb_n_lp];
  logic [vtag_w_lp-1:0] copy_vtag  [tlb_n_lp];
  pte_leaf_s            copy_entry [tlb_n_lp];
  int                   copy_victim;

  logic [vtag_w_lp-1:0] pool [pool_n_lp];

  mmu_top dut0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_i(cmd_i)
     ,.fill_v_i(fill_v_i)
     ,.fill_i(fill_i)
     ,.flush_i(flush_i)
     ,.translation_en_i(translation_en_i)
     ,.priv_mode_i(priv_mode_i)
     ,.mstatus_sum_i(mstatus_sum_i)
     ,.uncached_mode_i(uncached_mode_i)
     ,.poison_i(poison_i)
     ,.resp_v_o(resp_v_o)
     ,.resp_o(resp_o)
     );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic report_failure(input string msg);
    $display("ERROR @ %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first mismatch");
  endtask

  function automatic string describe(input mmu_resp_s r);
    return $sformatf("paddr %h miss %b lpf %b spf %b laf %b saf %b", r.paddr, r.miss_v,
                     r.load_page_fault, r.store_page_fault, r.load_access_fault,
                     r.store_access_fault);
  endfunction

  // Physical address only matters when the access is not a miss
  function automatic logic resp_matches(input mmu_resp_s got, input mmu_resp_s want);
    logic flags_ok;
    flags_ok = (got.miss_v === want.miss_v)
             && (got.load_page_fault === want.load_page_fault)
             && (got.store_page_fault === want.store_page_fault)
             && (got.load_access_fault === want.load_access_fault)
             && (got.store_access_fault === want.store_access_fault);
    return flags_ok && (want.miss_v || (got.paddr === want.paddr));
  endfunction

  a_resp_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o === exp_v)
    else report_failure($sformatf("resp_v_o is %b, expected %b",
                                  $sampled(resp_v_o), $sampled(exp_v)));

  a_resp_data: assert property (@(posedge clk_i) disable iff (reset_i)
    exp_v |-> resp_matches(resp_o, exp_resp))
    else report_failure($sformatf("resp_o is %s, expected %s",
                                  describe($sampled(resp_o)), describe($sampled(exp_resp))));

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  function automatic logic [ptag_w_lp-1:0] random_ptag();
    logic [31:0]          r;
    logic [ptag_w_lp-1:0] tag;
    r   = next_random();
    tag = r[ptag_w_lp-1:0];
    // Mostly domain 0, and about half of those below DRAM
    if (r[31:30] != 2'b11) begin
      tag[ptag_w_lp-1 -: did_w_lp] = '0;
    end
    if (r[29]) begin
      tag = tag % `MMU_DRAM_BASE_PTAG;
    end
    return tag;
  endfunction

  function automatic void find_entry(input logic [vtag_w_lp-1:0] vtag, output logic hit,
                                     output pte_leaf_s e);
    hit = 1'b0;
    e   = '0;
    for (int i = 0; i < tlb_n_lp; i++) begin
      if (copy_valid[i] && (copy_vtag[i] == vtag)) begin
        hit = 1'b1;
        e   = copy_entry[i];
      end
    end
  endfunction

  // Same tag overwrites in place, else the round-robin victim
  function automatic void insert_entry(input tlb_fill_s f);
    int slot;
    slot = -1;
    for (int i = 0; i < tlb_n_lp; i++) begin
      if (copy_valid[i] && (copy_vtag[i] == f.vtag)) begin
        slot = i;
      end
    end
    if (slot < 0) begin
      slot        = copy_victim;
      copy_victim = (copy_victim + 1) % tlb_n_lp;
    end
    copy_valid[slot] = 1'b1;
    copy_vtag[slot]  = f.vtag;
    copy_entry[slot] = f.entry;
  endfunction

  function automatic void clear_entries();
    for (int i = 0; i < tlb_n_lp; i++) begin
      copy_valid[i] = 1'b0;
    end
  endfunction

  function automatic mmu_resp_s expected_resp(input mmu_cmd_s cmd);
    mmu_resp_s            r;
    logic [vtag_w_lp-1:0] vtag;
    logic                 hit;
    pte_leaf_s            e;
    logic [ptag_w_lp-1:0] tag;
    logic                 priv_bad;
    logic                 write_bad;
    logic                 attr_bad;
    r    = '0;
    vtag = cmd.vaddr[`MMU_VADDR_WIDTH-1 -: vtag_w_lp];
    find_entry(vtag, hit, e);
    if (translation_en_i && !hit) begin
      r.miss_v = 1'b1;
      return r;
    end
    tag     = translation_en_i ? e.ptag : ptag_w_lp'(vtag);
    r.paddr = {tag, cmd.vaddr[off_w_lp-1:0]};
    if (translation_en_i) begin
      priv_bad = ((priv_mode_i == e_priv_user) && !e.u)
               || ((priv_mode_i == e_priv_supervisor) && e.u && !mstatus_sum_i);
      write_bad = !e.w || !e.d;
      r.load_page_fault  = !cmd.store && priv_bad;
      r.store_page_fault = cmd.store && (priv_bad || write_bad);
    end
    attr_bad = (tag[ptag_w_lp-1 -: did_w_lp] != '0)
             || (uncached_mode_i && (tag >= `MMU_DRAM_BASE_PTAG));
    r.load_access_fault  = !cmd.store && attr_bad;
    r.store_access_fault = cmd.store && attr_bad;
    return r;
  endfunction

  // One falling edge: update expectations, then drive the inputs
  task automatic drive_cycle(input logic v, input mmu_cmd_s cmd, input logic fill_v,
                             input tlb_fill_s fill, input logic flush, input logic poison);
    expect_s item;
    @(negedge clk_i);
    if ((exp_q.size() != 0) && (exp_q[0].due == edge_cnt + 1)) begin
      exp_v    = 1'b1;
      exp_resp = exp_q[0].resp;
      void'(exp_q.pop_front());
    end else begin
      exp_v = 1'b0;
    end
    // Poison now hits the command issued one cycle earlier
    if (poison && (exp_q.size() != 0) && (exp_q[$].due == edge_cnt + 2)) begin
      void'(exp_q.pop_back());
    end
    if (v) begin
      item.due  = edge_cnt + 3;
      item.resp = expected_resp(cmd);
      exp_q.push_back(item);
    end
    if (flush) begin
      clear_entries();
    end else if (fill_v) begin
      insert_entry(fill);
    end
    cmd_v_i  = v;
    cmd_i    = cmd;
    fill_v_i = fill_v;
    fill_i   = fill;
    flush_i  = flush;
    poison_i = poison;
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    end
  endtask

  task automatic send_access(input logic [vtag_w_lp-1:0] vtag,
                             input logic [off_w_lp-1:0] offset, input logic store);
    mmu_cmd_s cmd;
    cmd.vaddr = {vtag, offset};
    cmd.store = store;
    drive_cycle(1'b1, cmd, 1'b0, '0, 1'b0, 1'b0);
  endtask

  task automatic fill_entry(input logic [vtag_w_lp-1:0] vtag,
                            input logic [ptag_w_lp-1:0] ptag,
                            input logic u, input logic w, input logic d);
    tlb_fill_s f;
    f.vtag       = vtag;
    f.entry.ptag = ptag;
    f.entry.u    = u;
    f.entry.w    = w;
    f.entry.d    = d;
    drive_cycle(1'b0, '0, 1'b1, f, 1'b0, 1'b0);
  endtask

  task automatic flush_tlb();
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
  endtask

  // Level inputs only change once the pipeline is empty
  task automatic set_mode(input logic en, input priv_mode_e priv, input logic sum,
                          input logic unc);
    idle(3);
    translation_en_i = en;
    priv_mode_i      = priv;
    mstatus_sum_i    = sum;
    uncached_mode_i  = unc;
  endtask

  // Back-to-back commands over the tag pool, with a fill every fourth cycle
  task automatic run_stream(input int n, input logic with_poison);
    logic [31:0] r;
    mmu_cmd_s    cmd;
    tlb_fill_s   f;
    for (int i = 0; i < n; i++) begin
      r            = next_random();
      cmd.vaddr    = {pool[r[3:0] % pool_n_lp], r[15:4]};
      cmd.store    = r[16];
      f.vtag       = pool[r[23:20] % pool_n_lp];
      f.entry.ptag = random_ptag();
      f.entry.u    = r[17];
      f.entry.w    = r[18];
      f.entry.d    = r[19];
      drive_cycle(1'b1, cmd, (i % 4) == 3, f, 1'b0, with_poison && (r[25:24] == 2'b11));
    end
  endtask

  initial begin
    #(watchdog_ns_lp);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns_lp);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0]          r;
    logic [31:0]          r2;
    logic [vtag_w_lp-1:0] vtag;
    priv_mode_e           priv;
    seed             = 32'hfb89;
    reset_i          = 1'b1;
    cmd_v_i          = 1'b0;
    cmd_i            = '0;
    fill_v_i         = 1'b0;
    fill_i           = '0;
    flush_i          = 1'b0;
    translation_en_i = 1'b0;
    priv_mode_i      = e_priv_machine;
    mstatus_sum_i    = 1'b0;
    uncached_mode_i  = 1'b0;
    poison_i         = 1'b0;
    exp_v            = 1'b0;
    exp_resp         = '0;
    copy_victim      = 0;
    clear_entries();
    repeat (reset_cycles_lp) @(negedge clk_i);
    reset_i = 1'b0;

    // Translation off, uncached mode off then on
    for (int unc = 0; unc < 2; unc++) begin
      set_mode(1'b0, e_priv_machine, 1'b0, unc == 1);
      for (int i = 0; i < n_rand_lp; i++) begin
        r    = next_random();
        r2   = next_random();
        vtag = r[vtag_w_lp-1:0];
        if (r[30]) begin
          vtag[vtag_w_lp-1 -: 2] = '0;
        end
        if (r[31]) begin
          vtag = vtag % `MMU_DRAM_BASE_PTAG;
        end
        send_access(vtag, r2[off_w_lp-1:0], r2[12]);
      end
    end

    // Fills then hits, and lookups of tags never filled
    set_mode(1'b1, e_priv_machine, 1'b0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      r       = next_random();
      pool[i] = {r[22:0], 4'(i)};
      fill_entry(pool[i], random_ptag(), 1'b1, 1'b1, 1'b1);
    end
    for (int i = 0; i < 6; i++) begin
      r = next_random();
      send_access(pool[i], r[off_w_lp-1:0], r[12]);
    end
    for (int i = 0; i < 4; i++) begin
      r = next_random();
      send_access({r[22:0], 4'hf}, r[off_w_lp-1:0], r[12]);
    end

    // Replacement: twelve tags into eight entries, a refill, then a flush
    flush_tlb();
    for (int i = 0; i < pool_n_lp; i++) begin
      pool[i] = vtag_w_lp'(32'h100 + i);
      fill_entry(pool[i], random_ptag(), 1'b1, 1'b1, 1'b1);
    end
    for (int i = 0; i < pool_n_lp; i++) begin
      r = next_random();
      send_access(pool[i], r[off_w_lp-1:0], 1'b0);
    end
    fill_entry(pool[8], random_ptag(), 1'b1, 1'b1, 1'b1);
    for (int i = 0; i < pool_n_lp; i++) begin
      r = next_random();
      send_access(pool[i], r[off_w_lp-1:0], 1'b1);
    end
    flush_tlb();
    for (int i = 0; i < pool_n_lp; i++) begin
      r = next_random();
      send_access(pool[i], r[off_w_lp-1:0], r[12]);
    end

    // Every u, w, d combination under each privilege setting
    flush_tlb();
    for (int i = 0; i < 8; i++) begin
      fill_entry(vtag_w_lp'(32'h200 + i), random_ptag(), i[2], i[1], i[0]);
    end
    for (int m = 0; m < 5; m++) begin
      priv = (m < 2) ? e_priv_user : ((m < 4) ? e_priv_supervisor : e_priv_machine);
      set_mode(1'b1, priv, m[0], m[1]);
      for (int i = 0; i < 8; i++) begin
        for (int s = 0; s < 2; s++) begin
          r = next_random();
          send_access(vtag_w_lp'(32'h200 + i), r[off_w_lp-1:0], s == 1);
        end
      end
    end

    // Continuous streams, the second one with poison
    for (int i = 0; i < pool_n_lp; i++) begin
      r       = next_random();
      pool[i] = r[vtag_w_lp-1:0];
    end
    set_mode(1'b1, e_priv_supervisor, 1'b1, 1'b0);
    run_stream(n_stream_lp, 1'b0);
    set_mode(1'b1, e_priv_user, 1'b0, 1'b0);
    run_stream(n_stream_lp, 1'b1);
    idle(4);

    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      $display("ERRORS FOUND");
      $fatal(1, "run ended with responses outstanding");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* src/mmu_top.sv */
// Data translation pipeline: TLB lookup, fault checks, poison kill and two-stage response
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module mmu_top
  import mmu_pkg::*;
  (input  logic        clk_i
   , input  logic        reset_i

   , input  logic        cmd_v_i
   , input  mmu_cmd_s    cmd_i

   , input  logic        fill_v_i
   , input  tlb_fill_s   fill_i
   , input  logic        flush_i

   , input  logic        translation_en_i
   , input  priv_mode_e  priv_mode_i
   , input  logic        mstatus_sum_i
   , input  logic        uncached_mode_i

   , input  logic        poison_i

   , output logic        resp_v_o
   , output mmu_resp_s   resp_o
   );

  localparam int unsigned ptag_width_lp = `MMU_PTAG_WIDTH;

  logic [`MMU_VTAG_WIDTH-1:0]        cmd_vtag;

  // Stage 1 command fields
  logic                              cmd_v_r;
  logic                              store_r;
  logic [`MMU_PAGE_OFFSET_WIDTH-1:0] offset_r;
  logic [`MMU_PTAG_WIDTH-1:0]        passthrough_ptag_r;

  logic                              dtlb_hit;
  logic                              dtlb_miss;
  pte_leaf_s                         dtlb_entry;

  logic [`MMU_PTAG_WIDTH-1:0]        ptag;
  logic                              load_page_fault;
  logic                              store_page_fault;
  logic                              load_access_fault;
  logic                              store_access_fault;
  logic                              miss_s1;

  assign cmd_vtag = cmd_i.vaddr[`MMU_VADDR_WIDTH-1 -: `MMU_VTAG_WIDTH];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_r <= 1'b0;
    end else begin
      cmd_v_r <= cmd_v_i;
    end
  end

  // Untranslated tag is the zero-extended virtual tag
  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      store_r            <= cmd_i.store;
      offset_r           <= cmd_i.vaddr[`MMU_PAGE_OFFSET_WIDTH-1:0];
      passthrough_ptag_r <= ptag_width_lp'(cmd_vtag);
    end
  end

  dtlb dtlb0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)

     ,.lookup_v_i(cmd_v_i)
     ,.lookup_vtag_i(cmd_vtag)

     ,.fill_v_i(fill_v_i)
     ,.fill_i(fill_i)

     ,.hit_o(dtlb_hit)
     ,.miss_o(dtlb_miss)
     ,.entry_o(dtlb_entry)
     );

  access_check check0
    (.v_i(cmd_v_r)
     ,.store_i(store_r)
     ,.hit_i(dtlb_hit)
     ,.entry_i(dtlb_entry)
     ,.passthrough_ptag_i(passthrough_ptag_r)

     ,.translation_en_i(translation_en_i)
     ,.priv_mode_i(priv_mode_i)
     ,.mstatus_sum_i(mstatus_sum_i)
     ,.uncached_mode_i(uncached_mode_i)

     ,.ptag_o(ptag)
     ,.uncached_o()
     ,.load_page_fault_o(load_page_fault)
     ,.store_page_fault_o(store_page_fault)
     ,.load_access_fault_o(load_access_fault)
     ,.store_access_fault_o(store_access_fault)
     );

  // A TLB miss only counts with translation on
  assign miss_s1 = translation_en_i && dtlb_miss;

  // Poison in stage 1 kills the response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= cmd_v_r && !poison_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_r) begin
      resp_o.paddr              <= {ptag, offset_r};
      resp_o.miss_v             <= miss_s1;
      resp_o.load_page_fault    <= load_page_fault && !miss_s1;
      resp_o.store_page_fault   <= store_page_fault && !miss_s1;
      resp_o.load_access_fault  <= load_access_fault && !miss_s1;
      resp_o.store_access_fault <= store_access_fault && !miss_s1;
    end
  end

  a_miss_no_fault: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> !(resp_o.miss_v && (resp_o.load_page_fault || resp_o.store_page_fault
                                     || resp_o.load_access_fault
                                     || resp_o.store_access_fault)))
    else $error("mmu_top: response carries a miss and a fault");

endmodule

`default_nettype wire

/* src/access_check.sv */
// Page-permission and physical-memory-attribute fault checks for one looked-up access
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module access_check
  import mmu_pkg::*;
  (input  logic                       v_i
   , input  logic                       store_i
   , input  logic                       hit_i
   , input  pte_leaf_s                  entry_i
   , input  logic [`MMU_PTAG_WIDTH-1:0] passthrough_ptag_i

   , input  logic                       translation_en_i
   , input  priv_mode_e                 priv_mode_i
   , input  logic                       mstatus_sum_i
   , input  logic                       uncached_mode_i

   , output logic [`MMU_PTAG_WIDTH-1:0] ptag_o
   , output logic                       uncached_o
   , output logic                       load_page_fault_o
   , output logic                       store_page_fault_o
   , output logic                       load_access_fault_o
   , output logic                       store_access_fault_o
   );

  logic translated_hit;
  logic priv_fault;
  logic write_fault;
  logic did_fault;
  logic mode_fault;

  assign ptag_o = translation_en_i ? entry_i.ptag : passthrough_ptag_i;

  // Page checks only apply to a translated hit
  assign translated_hit = v_i && translation_en_i && hit_i;

  // Supervisor may touch user pages only with SUM
  assign priv_fault = ((priv_mode_i == e_priv_supervisor) && entry_i.u && !mstatus_sum_i)
                    || ((priv_mode_i == e_priv_user) && !entry_i.u);
  assign write_fault = store_i && (!entry_i.w || !entry_i.d);

  assign load_page_fault_o  = translated_hit && !store_i && priv_fault;
  assign store_page_fault_o = translated_hit && store_i && (priv_fault || write_fault);

  // Memory attributes of the effective tag
  assign uncached_o = (ptag_o < `MMU_DRAM_BASE_PTAG);
  assign did_fault  = |ptag_o[`MMU_PTAG_WIDTH-1 -: `MMU_DID_WIDTH];
  assign mode_fault = uncached_mode_i && !uncached_o;

  // A miss is masked downstream
  assign load_access_fault_o  = v_i && !store_i && (did_fault || mode_fault);
  assign store_access_fault_o = v_i && store_i && (did_fault || mode_fault);

  always_comb begin
    a_fault_needs_v: assert final (v_i || !(load_page_fault_o || store_page_fault_o
                                           || load_access_fault_o || store_access_fault_o))
      else $error("access_check: fault raised without a valid access");
    a_one_direction: assert final (!((load_page_fault_o || load_access_fault_o)
                                     && (store_page_fault_o || store_access_fault_o)))
      else $error("access_check: load and store faults raised together");
  end

endmodule

`default_nettype wire

/* src/dtlb.sv */
// Fully associative data TLB with registered lookup, fill port and round-robin victim
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module dtlb
  import mmu_pkg::*;
  (input  logic                       clk_i
   , input  logic                       reset_i
   , input  logic                       flush_i

   , input  logic                       lookup_v_i
   , input  logic [`MMU_VTAG_WIDTH-1:0] lookup_vtag_i

   , input  logic                       fill_v_i
   , input  tlb_fill_s                  fill_i

   , output logic                       hit_o
   , output logic                       miss_o
   , output pte_leaf_s                  entry_o
   );

  localparam int unsigned entries_lp   = `MMU_TLB_ENTRIES;
  localparam int unsigned idx_width_lp = $clog2(entries_lp);

  logic [entries_lp-1:0]      valid_r;
  logic [`MMU_VTAG_WIDTH-1:0] vtag_r [entries_lp];
  pte_leaf_s                  entry_r [entries_lp];
  logic [idx_width_lp-1:0]    victim_r;

  logic [entries_lp-1:0]      lookup_match;
  logic [entries_lp-1:0]      fill_match;
  pte_leaf_s                  lookup_entry;
  logic [idx_width_lp-1:0]    fill_match_idx;
  logic [idx_width_lp-1:0]    fill_idx;
  logic                       fill_en;

  // Parallel tag compare for both ports
  always_comb begin
    for (int i = 0; i < entries_lp; i++) begin
      lookup_match[i] = valid_r[i] && (vtag_r[i] == lookup_vtag_i);
      fill_match[i]   = valid_r[i] && (vtag_r[i] == fill_i.vtag);
    end
  end

  // At most one entry matches, so a plain scan picks it
  always_comb begin
    lookup_entry   = '0;
    fill_match_idx = '0;
    for (int i = 0; i < entries_lp; i++) begin
      if (lookup_match[i]) begin
        lookup_entry = entry_r[i];
      end
      if (fill_match[i]) begin
        fill_match_idx = idx_width_lp'(i);
      end
    end
  end

  // Flush wins over a fill in the same cycle
  assign fill_en  = fill_v_i && !flush_i;
  assign fill_idx = (|fill_match) ? fill_match_idx : victim_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (flush_i) begin
      valid_r <= '0;
    end else if (fill_en) begin
      valid_r[fill_idx] <= 1'b1;
      // Refill of a present tag keeps the victim pointer
      if (!(|fill_match)) begin
        if (victim_r == idx_width_lp'(entries_lp - 1)) begin
          victim_r <= '0;
        end else begin
          victim_r <= victim_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_en) begin
      vtag_r[fill_idx]  <= fill_i.vtag;
      entry_r[fill_idx] <= fill_i.entry;
    end
  end

  // Lookup result for stage 1
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hit_o  <= 1'b0;
      miss_o <= 1'b0;
    end else begin
      hit_o  <= lookup_v_i && (|lookup_match);
      miss_o <= lookup_v_i && !(|lookup_match);
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_v_i) begin
      entry_o <= lookup_entry;
    end
  end

  // Fill path must never leave two entries with one tag
  a_single_match: assert property (@(posedge clk_i) disable iff (reset_i)
    lookup_v_i |-> $onehot0(lookup_match))
    else $error("dtlb: several valid entries match one lookup");

  // Exactly one result, and only one cycle after a lookup
  a_hit_xor_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    (hit_o || miss_o) |-> ($past(lookup_v_i) && (hit_o != miss_o)))
    else $error("dtlb: hit and miss out of step with lookup");

endmodule

`default_nettype wire

/* src/mmu_pkg.sv */
// Shared types of the data translation path: privilege, command, PTE, fill and response
`default_nettype none

`include "mmu_config.svh"

package mmu_pkg;

  typedef enum logic [1:0] {
    e_priv_user       = 2'b00,
    e_priv_supervisor = 2'b01,
    e_priv_machine    = 2'b11
  } priv_mode_e;

  // One load or store access
  typedef struct packed {
    logic [`MMU_VADDR_WIDTH-1:0] vaddr;
    logic                        store;
  } mmu_cmd_s;

  // Leaf PTE fields kept in the TLB
  typedef struct packed {
    logic [`MMU_PTAG_WIDTH-1:0] ptag;
    logic                       u;
    logic                       w;
    logic                       d;
  } pte_leaf_s;

  typedef struct packed {
    logic [`MMU_VTAG_WIDTH-1:0] vtag;
    pte_leaf_s                  entry;
  } tlb_fill_s;

  // Translation result, two cycles after the command
  typedef struct packed {
    logic [`MMU_PTAG_WIDTH+`MMU_PAGE_OFFSET_WIDTH-1:0] paddr;
    logic                                              miss_v;
    logic                                              load_page_fault;
    logic                                              store_page_fault;
    logic                                              load_access_fault;
    logic                                              store_access_fault;
  } mmu_resp_s;

endpackage

`default_nettype wire

/* include/mmu_config.svh */
// Address widths, TLB size and memory map of the data translation path
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Sv39 virtual address, 4 KiB pages
`define MMU_VADDR_WIDTH       39
`define MMU_PAGE_OFFSET_WIDTH 12
`define MMU_VTAG_WIDTH        27

// 40-bit physical address
`define MMU_PTAG_WIDTH        28

`define MMU_TLB_ENTRIES       8

// Top physical-tag bits select the domain, only domain 0 is reachable
`define MMU_DID_WIDTH         3

// Cacheable DRAM from 2 GiB upward
`define MMU_DRAM_BASE_PTAG    28'h008_0000

`endif
